// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_raycast_flatten
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+hw
hw/raycast_pkg.sv
hw/column_receiver.sv
hw/column_queue.sv
hw/column_flattener.sv
hw/raycast_flatten_top.sv
verif/tb_raycast_flatten.sv

// File: hw/column_flattener.sv
`timescale 1ns/100ps
`default_nettype none

`include "raycast_params.svh"

module column_flattener import raycast_pkg::*; (
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  map_select_t map_select,
    input  logic        valid,           // queue has a column
    input  column_t     head,
    output logic        pop,
    output logic        ray_valid,
    output pixel_addr_t ray_address,
    output pixel_t      ray_pixel,
    output logic        ray_last_pixel   // end of frame marker
);

    localparam vcount_t     LAST_ROW = vcount_t'(`SCREEN_HEIGHT - 1);
    localparam pixel_addr_t MAX_ADDR = pixel_addr_t'(`SCREEN_WIDTH * `SCREEN_HEIGHT - 1);

    flatten_state_t state;
    column_t        cur;        // column being swept
    vcount_t        row;
    region_t        region;
    logic           sweeping;
    logic           last_row;
    color_t         sky_color;
    color_t         ground_color;
    color_t         wall_color;
    pixel_t         pixel_next;
    pixel_addr_t    addr_next;

    assign sweeping = (state == SWEEP);
    assign last_row = sweeping && (row == LAST_ROW);

    // take a column when idle or right after the bottom row
    assign pop = valid && (!sweeping || last_row);

    // which part of the column this row falls in
    always_comb begin
        if (row < cur.draw_start) begin
            region = CEILING;
        end else if (row >= cur.draw_end) begin
            region = FLOOR;
        end else if (cur.map_data == '0) begin
            region = EMPTY_WALL;  // open cell shows sky
        end else begin
            region = SOLID_WALL;  // any nonzero cell, no textures
        end
    end

    // palette per map
    always_comb begin
        case (map_select)
            2'd2: begin
                sky_color    = 8'h18;
                ground_color = 8'h37;
                wall_color   = 8'h51;
            end
            default: begin  // maps 0, 1, 3
                sky_color    = 8'h2a;
                ground_color = 8'h51;
                wall_color   = 8'h5a;
            end
        endcase
    end

    always_comb begin
        pixel_next.shade = 1'b0;
        case (region)
            CEILING:    pixel_next.color = sky_color;
            FLOOR:      pixel_next.color = ground_color;
            EMPTY_WALL: pixel_next.color = sky_color;
            default: begin
                pixel_next.color = wall_color;
                pixel_next.shade = cur.wall_type;  // y side walls darker
            end
        endcase
    end

    // row major frame buffer address
    assign addr_next = pixel_addr_t'(cur.hcount)
                     + pixel_addr_t'(row) * pixel_addr_t'(`SCREEN_WIDTH);

    // sweep fsm
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            row   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    row <= '0;
                    if (valid) begin
                        state <= SWEEP;
                    end
                end
                SWEEP: begin
                    if (row == LAST_ROW) begin
                        row <= '0;
                        // next column starts straight away if one waits
                        state <= valid ? SWEEP : IDLE;
                    end else begin
                        row <= row + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // descriptor latch on pop
    always_ff @(posedge pixel_clk_in) begin
        if (pop) begin
            cur <= head;
        end
    end

    // output stage, flags reset
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            ray_valid      <= 1'b0;
            ray_last_pixel <= 1'b0;
        end else begin
            ray_valid      <= sweeping;
            ray_last_pixel <= last_row && cur.last;
        end
    end

    // payload
    always_ff @(posedge pixel_clk_in) begin
        ray_address <= addr_next;
        ray_pixel   <= pixel_next;
    end

    // registered address must stay inside the frame buffer
    assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        ray_valid |-> (ray_address <= MAX_ADDR))
        else $error("column_flattener: address out of range");

endmodule

`default_nettype wire

// File: hw/column_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "raycast_params.svh"

module column_queue import raycast_pkg::*; (
    input  logic    pixel_clk_in,
    input  logic    rst_in,
    input  logic    push,
    input  column_t push_column,
    input  logic    pop,
    output logic    full,
    output logic    valid,
    output column_t head
);

    localparam int DEPTH   = `COLUMN_QUEUE_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    column_t              mem [DEPTH];     // descriptor storage
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [COUNT_W-1:0]   count;           // 0..DEPTH entries

    // wrap a pointer at the depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid = (count != '0);
    assign full  = (count == COUNT_W'(DEPTH));
    assign head  = mem[rd_ptr];  // show ahead

    // pointers and occupancy
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // storage write
    always_ff @(posedge pixel_clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_column;
        end
    end

    assert property (@(posedge pixel_clk_in) disable iff (rst_in) push |-> !full)
        else $error("column_queue: push while full");

    assert property (@(posedge pixel_clk_in) disable iff (rst_in) pop |-> valid)
        else $error("column_queue: pop while empty");

endmodule

`default_nettype wire

// File: hw/column_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "raycast_params.svh"

module column_receiver import raycast_pkg::*; (
    input  logic       pixel_clk_in,
    input  logic       rst_in,
    input  logic       fifo_tvalid,
    input  fifo_word_t fifo_tdata,
    input  logic       fifo_tlast,
    input  logic [1:0] fb_ready_to_switch,  // one bit per buffer half
    input  logic       full,                // queue has no room
    output logic       fifo_tready,
    output logic       push,
    output column_t    push_column
);

    logic         gate_open;    // low between a tlast column and the buffer swap
    logic         accept;
    line_height_t line_height;
    vcount_t      half_height;
    column_t      decoded;

    // wallX bits fall away in the slicing
    assign line_height = fifo_tdata[`RAY_LHEIGHT_MSB:`RAY_LHEIGHT_LSB];
    assign half_height = line_height >> 1;

    always_comb begin
        decoded.hcount    = fifo_tdata[`RAY_HCOUNT_MSB:`RAY_HCOUNT_LSB];
        decoded.wall_type = fifo_tdata[`RAY_WALLTYPE_BIT];
        decoded.map_data  = fifo_tdata[`RAY_MAPDATA_MSB:`RAY_MAPDATA_LSB];
        decoded.last      = fifo_tlast;
        // top of slice clamps at row 0
        if (half_height >= `HALF_SCREEN_HEIGHT) begin
            decoded.draw_start = '0;
        end else begin
            decoded.draw_start = vcount_t'(`HALF_SCREEN_HEIGHT - half_height);
        end
        // exclusive bottom of slice clamps at screen height
        if (half_height >= (`SCREEN_HEIGHT - `HALF_SCREEN_HEIGHT)) begin
            decoded.draw_end = vcount_t'(`SCREEN_HEIGHT);
        end else begin
            decoded.draw_end = vcount_t'(`HALF_SCREEN_HEIGHT + half_height);
        end
    end

    // push cycle blocks the next word
    assign fifo_tready = !push && !full && gate_open;
    assign accept      = fifo_tvalid && fifo_tready;

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            push      <= 1'b0;
            gate_open <= 1'b1;
        end else begin
            push <= accept;  // single cycle strobe
            if (accept && fifo_tlast) begin
                gate_open <= 1'b0;  // hold off the next frame
            end else if (!gate_open && (fb_ready_to_switch == 2'b11)) begin
                gate_open <= 1'b1;  // both halves ready to swap
            end
        end
    end

    // descriptor register
    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            push_column <= decoded;
        end
    end

    // a push must find room in the queue
    assert property (@(posedge pixel_clk_in) disable iff (rst_in) push |-> !full)
        else $error("column_receiver: push into full queue");

endmodule

`default_nettype wire

// File: hw/raycast_flatten_top.sv
`timescale 1ns/100ps
`default_nettype none

module raycast_flatten_top import raycast_pkg::*; (
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  map_select_t map_select,
    // dda stream fifo
    input  logic        fifo_tvalid,
    input  fifo_word_t  fifo_tdata,
    input  logic        fifo_tlast,
    output logic        fifo_tready,
    // frame buffer write port
    input  logic [1:0]  fb_ready_to_switch,
    output logic        ray_valid,
    output pixel_addr_t ray_address,
    output pixel_t      ray_pixel,
    output logic        ray_last_pixel
);

    logic    push;
    column_t push_column;
    logic    full;
    logic    valid;
    column_t head;
    logic    pop;

    // decode words, hold the frame gate
    column_receiver receiver (
        .pixel_clk_in       (pixel_clk_in),
        .rst_in             (rst_in),
        .fifo_tvalid        (fifo_tvalid),
        .fifo_tdata         (fifo_tdata),
        .fifo_tlast         (fifo_tlast),
        .fb_ready_to_switch (fb_ready_to_switch),
        .full               (full),
        .fifo_tready        (fifo_tready),
        .push               (push),
        .push_column        (push_column)
    );

    // columns wait here during a sweep
    column_queue queue (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .push         (push),
        .push_column  (push_column),
        .pop          (pop),
        .full         (full),
        .valid        (valid),
        .head         (head)
    );

    // one frame buffer write per row
    column_flattener flattener (
        .pixel_clk_in   (pixel_clk_in),
        .rst_in         (rst_in),
        .map_select     (map_select),
        .valid          (valid),
        .head           (head),
        .pop            (pop),
        .ray_valid      (ray_valid),
        .ray_address    (ray_address),
        .ray_pixel      (ray_pixel),
        .ray_last_pixel (ray_last_pixel)
    );

endmodule

`default_nettype wire

// File: hw/raycast_params.svh
`ifndef RAYCAST_PARAMS_SVH
`define RAYCAST_PARAMS_SVH

// screen geometry, low-res frame buffer
`define SCREEN_WIDTH        320
`define SCREEN_HEIGHT       180
`define HALF_SCREEN_HEIGHT  90      // horizon row

// descriptors waiting behind the one being swept
`define COLUMN_QUEUE_DEPTH  2

// dda word as it leaves the stream fifo
`define FIFO_WORD_WIDTH     38

// field positions in the dda word, msb first
`define RAY_HCOUNT_MSB      37
`define RAY_HCOUNT_LSB      29
`define RAY_LHEIGHT_MSB     28
`define RAY_LHEIGHT_LSB     21
`define RAY_WALLTYPE_BIT    20      // 0 x side hit, 1 y side hit
`define RAY_MAPDATA_MSB     19
`define RAY_MAPDATA_LSB     16
`define RAY_WALLX_MSB       15      // texture coordinate
`define RAY_WALLX_LSB       0

`endif

// File: hw/raycast_pkg.sv
`default_nettype none

`include "raycast_params.svh"

package raycast_pkg;

    // plain vector widths
    typedef logic [8:0]  hcount_t;       // screen column 0..319
    typedef logic [7:0]  vcount_t;       // screen row 0..179, 180 = past bottom
    typedef logic [7:0]  line_height_t;  // projected wall height
    typedef logic [3:0]  map_data_t;     // map cell value
    typedef logic [7:0]  color_t;        // palette index
    typedef logic [15:0] pixel_addr_t;   // hcount + row*width
    typedef logic [1:0]  map_select_t;   // palette / level select

    typedef logic [`FIFO_WORD_WIDTH-1:0] fifo_word_t;

    // what the frame buffer stores per pixel
    typedef struct packed {
        logic   shade;   // darken on y side walls
        color_t color;
    } pixel_t;

    // one decoded column, wallX already dropped
    typedef struct packed {
        hcount_t   hcount;
        vcount_t   draw_start;  // first wall row
        vcount_t   draw_end;    // first floor row
        logic      wall_type;
        map_data_t map_data;
        logic      last;        // tlast of the frame
    } column_t;

    // flattener fsm
    typedef enum logic {
        IDLE,
        SWEEP
    } flatten_state_t;

    // where a row of a column lands
    typedef enum logic [1:0] {
        CEILING,
        FLOOR,
        EMPTY_WALL,   // inside slice but map cell empty
        SOLID_WALL
    } region_t;

endpackage

`default_nettype wire

// File: verif/tb_raycast_flatten.sv
`timescale 1ns/100ps
`default_nettype none

`include "raycast_params.svh"

module tb_raycast_flatten import raycast_pkg::*; ();

    localparam int ACCEPT_TIMEOUT = 1000;  // covers a full queue draining
    localparam int DRAIN_TIMEOUT  = 3000;
    localparam int GATE_HOLD      = 40;    // cycles the closed gate is watched

    logic        pixel_clk_in;
    logic        rst_in;
    map_select_t map_select;
    logic        fifo_tvalid;
    fifo_word_t  fifo_tdata;
    logic        fifo_tlast;
    logic        fifo_tready;
    logic [1:0]  fb_ready_to_switch;
    logic        ray_valid;
    pixel_addr_t ray_address;
    pixel_t      ray_pixel;
    logic        ray_last_pixel;

    int          mismatch_count = 0;
    int          failure_count  = 0;
    int          cycle_count    = 0;
    logic [31:0] lcg_state      = 32'd10057;

    // expected and observed writes in order
    pixel_addr_t exp_addr[$];
    pixel_t      exp_pix[$];
    logic        exp_last[$];
    pixel_addr_t got_addr[$];
    pixel_t      got_pix[$];
    logic        got_last[$];
    int          got_cycle[$];  // for the no-gap check

    raycast_flatten_top DUT (.*);

    initial begin
        pixel_clk_in = 1'b0;
        forever #2 pixel_clk_in = ~pixel_clk_in;
    end

    // write port monitor on the falling edge
    always @(negedge pixel_clk_in) begin
        cycle_count = cycle_count + 1;
        if (!rst_in && ray_valid) begin
            got_addr.push_back(ray_address);
            got_pix.push_back(ray_pixel);
            got_last.push_back(ray_last_pixel);
            got_cycle.push_back(cycle_count);
        end else if (!rst_in && ray_last_pixel) begin
            $display("ray_last_pixel is high without ray_valid at %0t", $time);
            failure_count++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned rand_below(input int unsigned limit);
        lcg_state = lcg_next(lcg_state);
        return (lcg_state >> 8) % limit;  // low bits of an lcg are weak
    endfunction

    function automatic fifo_word_t make_word(input hcount_t hc, input line_height_t lh,
                                             input logic wt, input map_data_t md);
        fifo_word_t w;
        w = '0;
        w[`RAY_HCOUNT_MSB:`RAY_HCOUNT_LSB]   = hc;
        w[`RAY_LHEIGHT_MSB:`RAY_LHEIGHT_LSB] = lh;
        w[`RAY_WALLTYPE_BIT]                 = wt;
        w[`RAY_MAPDATA_MSB:`RAY_MAPDATA_LSB] = md;
        w[`RAY_WALLX_MSB:`RAY_WALLX_LSB]     = 16'(rand_below(65536));  // ignored by dut
        return w;
    endfunction

    // reference pixel from the region and palette rules
    function automatic pixel_t model_pixel(input int row, input line_height_t lh,
                                           input logic wt, input map_data_t md,
                                           input map_select_t msel);
        int     top;
        int     bottom;
        color_t sky;
        color_t ground;
        pixel_t p;
        top    = `HALF_SCREEN_HEIGHT - int'(lh) / 2;
        bottom = `HALF_SCREEN_HEIGHT + int'(lh) / 2;
        if (top < 0) begin
            top = 0;
        end
        if (bottom > `SCREEN_HEIGHT) begin
            bottom = `SCREEN_HEIGHT;
        end
        sky    = (msel == 2'd2) ? 8'h18 : 8'h2a;
        ground = (msel == 2'd2) ? 8'h37 : 8'h51;
        p.shade = 1'b0;
        if (row < top || (row < bottom && md == '0)) begin
            p.color = sky;  // ceiling or open cell
        end else if (row >= bottom) begin
            p.color = ground;
        end else begin
            p.color = (msel == 2'd2) ? 8'h51 : 8'h5a;
            p.shade = wt;
        end
        return p;
    endfunction

    task automatic check_addr(input string name, input pixel_addr_t got, input pixel_addr_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    // offer one word, wait for the transfer edge, then queue its 180 writes
    task automatic send_column(input hcount_t hc, input line_height_t lh, input logic wt,
                               input map_data_t md, input logic last);
        int waited;
        waited = 0;
        @(negedge pixel_clk_in);
        fifo_tdata  = make_word(hc, lh, wt, md);
        fifo_tlast  = last;
        fifo_tvalid = 1'b1;
        while (!fifo_tready && waited < ACCEPT_TIMEOUT) begin
            @(negedge pixel_clk_in);
            waited++;
        end
        if (!fifo_tready) begin
            $display("timeout: word for column %0d was never accepted", hc);
            failure_count++;
            fifo_tvalid = 1'b0;
            return;
        end
        @(posedge pixel_clk_in);  // transfer happens here
        for (int row = 0; row < `SCREEN_HEIGHT; row++) begin
            exp_addr.push_back(pixel_addr_t'(int'(hc) + row * `SCREEN_WIDTH));
            exp_pix.push_back(model_pixel(row, lh, wt, md, map_select));
            exp_last.push_back(last && row == `SCREEN_HEIGHT - 1);
        end
    endtask

    task automatic release_stream();
        @(negedge pixel_clk_in);
        fifo_tvalid = 1'b0;
        fifo_tlast  = 1'b0;
    endtask

    // wait for every expected write, then compare in order
    task automatic check_writes();
        int waited;
        int n;
        waited = 0;
        while (got_addr.size() < exp_addr.size() && waited < DRAIN_TIMEOUT) begin
            @(posedge pixel_clk_in);
            waited++;
        end
        repeat (4) @(posedge pixel_clk_in);  // room for stray extra writes
        if (got_addr.size() != exp_addr.size()) begin
            $display("expected %0d writes but saw %0d", exp_addr.size(), got_addr.size());
            failure_count++;
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_addr("ray_address", got_addr[i], exp_addr[i]);
            check_pixel("ray_pixel", got_pix[i], exp_pix[i]);
            check_flag("ray_last_pixel", got_last[i], exp_last[i]);
            if ((i % `SCREEN_HEIGHT) != 0 && got_cycle[i] != got_cycle[i-1] + 1) begin
                $display("gap inside a column before write %0d", i);
                failure_count++;
            end
        end
        exp_addr.delete();
        exp_pix.delete();
        exp_last.delete();
        got_addr.delete();
        got_pix.delete();
        got_last.delete();
        got_cycle.delete();
    endtask

    task automatic reset_values();
        @(negedge pixel_clk_in);
        check_flag("fifo_tready", fifo_tready, 1'b1);
        check_flag("ray_valid", ray_valid, 1'b0);
        check_flag("ray_last_pixel", ray_last_pixel, 1'b0);
    endtask

    task automatic single_columns();
        map_select = 2'd0;
        send_column(9'd5, 8'd80, 1'b0, 4'd1, 1'b0);    // solid slice over rows 50..129
        release_stream();
        check_writes();
        send_column(9'd319, 8'd120, 1'b1, 4'd0, 1'b0); // empty cell shows sky
        release_stream();
        check_writes();
    endtask

    task automatic shade_and_palette();
        @(negedge pixel_clk_in);
        map_select = 2'd2;
        send_column(9'd100, 8'd100, 1'b1, 4'd3, 1'b0);
        release_stream();
        check_writes();
        @(negedge pixel_clk_in);
        map_select = 2'd0;
    endtask

    task automatic line_height_clamping();
        send_column(9'd200, 8'd255, 1'b1, 4'd2, 1'b0);  // wall over every row
        send_column(9'd201, 8'd0, 1'b1, 4'd1, 1'b0);    // no wall rows
        release_stream();
        check_writes();
    endtask

    task automatic back_to_back_columns();
        for (int i = 0; i < 6; i++) begin  // tvalid stays high throughout
            send_column(hcount_t'(rand_below(`SCREEN_WIDTH)), line_height_t'(rand_below(256)),
                        logic'(rand_below(2)), map_data_t'(rand_below(16)), 1'b0);
        end
        release_stream();
        check_writes();
    endtask

    task automatic frame_gate();
        send_column(9'd17, 8'd60, 1'b0, 4'd1, 1'b1);
        @(negedge pixel_clk_in);
        fifo_tdata  = make_word(9'd18, 8'd60, 1'b0, 4'd1);
        fifo_tlast  = 1'b0;
        fifo_tvalid = 1'b1;
        for (int i = 0; i < GATE_HOLD; i++) begin
            fb_ready_to_switch = (i < GATE_HOLD / 2) ? 2'b01 : 2'b10;  // one half only
            if (fifo_tready) begin
                $display("word accepted before the frame buffer was ready to switch");
                failure_count++;
                break;
            end
            @(negedge pixel_clk_in);
        end
        fb_ready_to_switch = 2'b11;
        send_column(9'd18, 8'd60, 1'b0, 4'd1, 1'b0);
        release_stream();
        fb_ready_to_switch = 2'b00;
        check_writes();
    endtask

    initial begin
        rst_in             = 1'b1;
        map_select         = 2'd0;
        fifo_tvalid        = 1'b0;
        fifo_tdata         = '0;
        fifo_tlast         = 1'b0;
        fb_ready_to_switch = 2'b00;
        repeat (5) @(negedge pixel_clk_in);
        rst_in = 1'b0;

        reset_values();
        single_columns();
        shade_and_palette();
        line_height_clamping();
        back_to_back_columns();
        frame_gate();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
